/* src/bridgePkg.sv */
/*
  Bus widths, peripheral address map, bus encodings and the
  packed command and APB control structs of the AHB to APB bridge
*/
`default_nettype none

package bridgePkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------
  // AHB address bus
  localparam int AhbAddrWidth = 32;
  // Data word, same on AHB and APB
  localparam int AhbDataWidth = 32;
  // Only the low part of the address reaches the peripherals
  localparam int PAddrWidth = 16;

  // ----------------------------------------------------------------------
  // Peripheral address map
  // ----------------------------------------------------------------------
  // Field of HADDR that picks the peripheral
  localparam int SelMsb = 27;
  localparam int SelLsb = 24;
  // Register block
  localparam logic [SelMsb-SelLsb:0] RegsBase = 4'h0;
  // Interrupt controller
  localparam logic [SelMsb-SelLsb:0] IntcBase = 4'h1;

  // HTRANS encoding
  typedef enum logic [1:0] {
    TransIdle   = 2'b00,
    TransBusy   = 2'b01,
    TransNonSeq = 2'b10,
    TransSeq    = 2'b11
  } hTransT;

  // HRESP encoding, bridge only ever answers OKAY
  typedef enum logic [1:0] {
    RespOkay  = 2'b00,
    RespError = 2'b01,
    RespRetry = 2'b10,
    RespSplit = 2'b11
  } hRespT;

  // APB sequencing states
  typedef enum logic [1:0] {
    StIdle      = 2'b00,
    StWriteWait = 2'b01,
    StSetup     = 2'b10,
    StEnable    = 2'b11
  } bridgeStateT;

  typedef logic [AhbAddrWidth-1:0] ahbAddrT;
  typedef logic [AhbDataWidth-1:0] ahbDataT;
  typedef logic [PAddrWidth-1:0]   pAddrT;

  // Address phase controls kept for the data phase
  typedef struct packed {
    ahbAddrT addr;
    logic    write;
  } ahbCmdT;

  // APB control outputs, PWDATA travels on its own
  typedef struct packed {
    pAddrT pAddr;
    logic  pWrite;
    logic  pSelRegs;
    logic  pSelIntc;
    logic  pEnable;
  } apbCtrlT;

endpackage

`default_nettype wire

/* src/ahbCapture.sv */
/*
  Valid AHB transfer detection and the address phase command register
*/
`timescale 1ns/10ps
`default_nettype none

module ahbCapture (
  input  logic              HCLK,
  input  logic              HRESETn,
  input  logic              HSELAHBAPB,
  input  bridgePkg::hTransT HTRANS,
  input  logic              HWRITE,
  input  bridgePkg::ahbAddrT HADDR,
  input  logic              HREADYIn,
  output logic              cmdValid,
  output bridgePkg::ahbCmdT cmd
);
  import bridgePkg::*;

  // Real transfer to the bridge in this address phase
  logic accept;

  // IDLE and BUSY are ignored, and nothing is taken while the bus waits
  assign accept = HSELAHBAPB && HREADYIn &&
                  ((HTRANS == TransNonSeq) || (HTRANS == TransSeq));

  // One cycle pulse per accepted transfer, lines up with the data phase
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      cmdValid <= 1'b0;
    else
      cmdValid <= accept;
  end

  // Address and direction held until the next accepted transfer
  always_ff @(posedge HCLK)
  begin
    if (accept)
    begin
      cmd.addr  <= HADDR;
      cmd.write <= HWRITE;
    end
  end

endmodule

`default_nettype wire

/* src/bridgeFsm.sv */
/*
  APB sequencing state machine with registered HREADYOut wait states
*/
`timescale 1ns/10ps
`default_nettype none

module bridgeFsm (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  logic                   cmdValid,
  input  bridgePkg::ahbCmdT      cmd,
  output bridgePkg::bridgeStateT state,
  output logic                   loadSetup,
  output logic                   HREADYOut
);
  import bridgePkg::*;

  bridgeStateT nextState;
  // Next value of the ready register
  logic        readyNext;

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------
  always_comb
  begin
    case (state)
      // Waiting for a transfer
      StIdle:
      begin
        if (cmdValid)
          // Writes need one cycle to get HWDATA into PWDATA
          nextState = cmd.write ? StWriteWait : StSetup;
        else
          nextState = StIdle;
      end
      // PWDATA is being loaded
      StWriteWait:
        nextState = StSetup;
      // PSEL up, PENABLE follows
      StSetup:
        nextState = StEnable;
      // Last APB cycle, a new transfer may chain straight on
      StEnable:
      begin
        if (cmdValid)
          nextState = cmd.write ? StWriteWait : StSetup;
        else
          nextState = StIdle;
      end
      // Recover from a bad encoding
      default:
        nextState = StIdle;
    endcase
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      state <= StIdle;
    else
      state <= nextState;
  end

  // APB driver loads address and selects when setup comes next
  assign loadSetup = (nextState == StSetup);

  // ----------------------------------------------------------------------
  // HREADYOut
  // ----------------------------------------------------------------------
  // Wait states while PWDATA loads and during setup,
  // so the data phase ends in the enable cycle
  assign readyNext = !((nextState == StWriteWait) || (nextState == StSetup));

  // Registered for a clean output path onto the AHB
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      HREADYOut <= 1'b1;
    else
      HREADYOut <= readyNext;
  end

endmodule

`default_nettype wire

/* src/apbDriver.sv */
/*
  Peripheral select decode, APB control output registers
  and the PWDATA register
*/
`timescale 1ns/10ps
`default_nettype none

module apbDriver (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  bridgePkg::bridgeStateT state,
  input  logic                   loadSetup,
  input  bridgePkg::ahbCmdT      cmd,
  input  bridgePkg::ahbDataT     HWDATA,
  output bridgePkg::apbCtrlT     apb,
  output bridgePkg::ahbDataT     PWDATA
);
  import bridgePkg::*;

  // Peripheral field of the captured address
  logic [SelMsb-SelLsb:0] selField;
  logic                   selRegs;
  logic                   selIntc;

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  assign selField = cmd.addr[SelMsb:SelLsb];

  // Unmapped field values select nothing,
  // the rest of the APB cycle still runs
  assign selRegs = (selField == RegsBase);
  assign selIntc = (selField == IntcBase);

  // ----------------------------------------------------------------------
  // APB control registers
  // ----------------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      apb <= '0;
    end
    else
    begin
      // High for exactly the cycle after setup
      apb.pEnable <= (state == StSetup);
      if (loadSetup)
      begin
        // Start of a setup phase
        apb.pAddr    <= cmd.addr[PAddrWidth-1:0];
        apb.pWrite   <= cmd.write;
        apb.pSelRegs <= selRegs;
        apb.pSelIntc <= selIntc;
      end
      else if (state == StEnable)
      begin
        // Transfer done, drop the selects
        // address and direction stay as they were
        apb.pSelRegs <= 1'b0;
        apb.pSelIntc <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Write data
  // ----------------------------------------------------------------------
  // HWDATA is stable in the wait state, held through setup and enable
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      PWDATA <= '0;
    else if (state == StWriteWait)
      PWDATA <= HWDATA;
  end

endmodule

`default_nettype wire

/* src/ahbToApbBridge.sv */
/*
  AHB to APB bridge top level, capture, state machine and APB driver
*/
`timescale 1ns/10ps
`default_nettype none

module ahbToApbBridge (
  input  logic                HCLK,
  input  logic                HRESETn,
  // AHB slave side
  input  logic                HSELAHBAPB,
  input  bridgePkg::hTransT   HTRANS,
  input  logic                HWRITE,
  input  bridgePkg::ahbAddrT  HADDR,
  input  bridgePkg::ahbDataT  HWDATA,
  input  logic                HREADYIn,
  output logic                HREADYOut,
  output bridgePkg::hRespT    HRESP,
  output bridgePkg::ahbDataT  HRDATA,
  // APB master side
  output bridgePkg::apbCtrlT  apb,
  output bridgePkg::ahbDataT  PWDATA,
  input  bridgePkg::ahbDataT  PRDATA
);
  import bridgePkg::*;

  // Captured transfer
  logic        cmdValid;
  ahbCmdT      cmd;
  // Sequencing towards the APB driver
  bridgeStateT state;
  logic        loadSetup;

  // ----------------------------------------------------------------------
  // Address phase capture
  // ----------------------------------------------------------------------
  ahbCapture i_capture (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .HSELAHBAPB (HSELAHBAPB),
    .HTRANS     (HTRANS),
    .HWRITE     (HWRITE),
    .HADDR      (HADDR),
    .HREADYIn   (HREADYIn),
    .cmdValid   (cmdValid),
    .cmd        (cmd)
  );

  // Wait states and APB phase sequencing
  bridgeFsm i_fsm (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .cmdValid  (cmdValid),
    .cmd       (cmd),
    .state     (state),
    .loadSetup (loadSetup),
    .HREADYOut (HREADYOut)
  );

  // APB outputs
  apbDriver i_driver (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .state     (state),
    .loadSetup (loadSetup),
    .cmd       (cmd),
    .HWDATA    (HWDATA),
    .apb       (apb),
    .PWDATA    (PWDATA)
  );

  // No error paths, every transfer completes
  assign HRESP = RespOkay;

  // Read data only valid in the enable cycle, where HREADYOut is high
  assign HRDATA = PRDATA;

endmodule

`default_nettype wire

/* tests/apbMonitor.sv */
/*
  Checker watching the bridge ports against the current table entry
*/
`timescale 1ns/10ps
`default_nettype none

module apbMonitor (
  input  logic               HCLK,
  input  logic               HRESETn,
  input  logic               HREADYOut,
  input  bridgePkg::hRespT   HRESP,
  input  bridgePkg::ahbDataT HRDATA,
  input  bridgePkg::apbCtrlT apb,
  input  bridgePkg::ahbDataT PWDATA,
  input  logic               start,
  input  logic               finish,
  input  logic [95:0]        expName,
  input  bridgePkg::hTransT  expTrans,
  input  bridgePkg::ahbAddrT expAddr,
  input  logic               expWrite,
  input  bridgePkg::ahbDataT expWData,
  input  bridgePkg::ahbDataT expRData,
  output int                 testCount,
  output int                 failCount,
  output int                 errorCount
);
  import bridgePkg::*;

  logic [95:0] curName;
  ahbAddrT     curAddr;
  logic        curWrite;
  ahbDataT     curWData;
  ahbDataT     curRData;
  logic        haveTest = 1'b0;
  logic        prevReset = 1'b0;
  logic        prevEnable = 1'b0;
  // APB controls of the previous cycle, the setup phase before an enable
  apbCtrlT     prevCtrl = '0;
  logic        lenSeen;
  logic        isXfer;
  logic        mapped;
  int          enCount;
  int          lowRun = 0;
  int          testErrors;

  initial
  begin
    testCount  = 0;
    failCount  = 0;
    errorCount = 0;
  end

  task automatic checkValue(input logic [95:0] name, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("mismatch %0s %0s expected %h actual %h", name, what, exp, act);
      testErrors = testErrors + 1;
      errorCount = errorCount + 1;
    end
  endtask

  task automatic reportTest();
    if (enCount != (isXfer ? 1 : 0))
    begin
      $display("%0s gave %0d enable cycles instead of %0d", curName, enCount, isXfer ? 1 : 0);
      testErrors = testErrors + 1;
      errorCount = errorCount + 1;
    end
    if (isXfer && !lenSeen)
    begin
      $display("%0s never finished its AHB data phase", curName);
      testErrors = testErrors + 1;
      errorCount = errorCount + 1;
    end
    testCount = testCount + 1;
    if (testErrors == 0)
      $display("pass %0s", curName);
    else
    begin
      failCount = failCount + 1;
      $display("fail %0s with %0d errors", curName, testErrors);
    end
  endtask

  always @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      prevReset  = 1'b1;
      prevEnable = 1'b0;
      prevCtrl   = '0;
      lowRun     = 0;
    end
    else
    begin
      // First cycle out of reset
      if (prevReset)
      begin
        checkValue("reset", "PSEL regs", 0, apb.pSelRegs);
        checkValue("reset", "PSEL intc", 0, apb.pSelIntc);
        checkValue("reset", "PENABLE", 0, apb.pEnable);
        checkValue("reset", "PWRITE", 0, apb.pWrite);
        checkValue("reset", "HREADYOut", 1, HREADYOut);
        prevReset = 1'b0;
      end
      checkValue(curName, "HRESP", 32'(RespOkay), 32'(HRESP));
      // ----------------------------------------------------------------
      // Enable cycle
      // ----------------------------------------------------------------
      if (apb.pEnable)
      begin
        enCount = enCount + 1;
        if (prevEnable)
        begin
          $display("PENABLE stayed high for more than one cycle in %0s", curName);
          errorCount = errorCount + 1;
          testErrors = testErrors + 1;
        end
        // Setup cycle carries the same select, address and direction
        if ({prevCtrl.pAddr, prevCtrl.pWrite, prevCtrl.pSelRegs, prevCtrl.pSelIntc} !==
            {apb.pAddr, apb.pWrite, apb.pSelRegs, apb.pSelIntc})
        begin
          $display("APB setup cycle missing or changed before the enable cycle in %0s",
                   curName);
          errorCount = errorCount + 1;
          testErrors = testErrors + 1;
        end
        if (!haveTest)
        begin
          $display("APB enable cycle seen with no transfer in progress");
          errorCount = errorCount + 1;
        end
        else
        begin
          // Bits 27:24 pick the peripheral as 0 for registers and 1 for the interrupt controller
          mapped = (curAddr[27:24] == 4'h0) || (curAddr[27:24] == 4'h1);
          checkValue(curName, "PSEL regs", curAddr[27:24] == 4'h0, apb.pSelRegs);
          checkValue(curName, "PSEL intc", curAddr[27:24] == 4'h1, apb.pSelIntc);
          checkValue(curName, "PADDR", curAddr[15:0], apb.pAddr);
          checkValue(curName, "PWRITE", curWrite, apb.pWrite);
          checkValue(curName, "HREADYOut", 1, HREADYOut);
          if (curWrite)
            checkValue(curName, "PWDATA", curWData, PWDATA);
          else
            checkValue(curName, "HRDATA", mapped ? curRData : 32'h0, HRDATA);
        end
      end
      prevEnable = apb.pEnable;
      prevCtrl   = apb;
      // Data phase length counts wait states plus the final ready cycle
      if (!HREADYOut)
        lowRun = lowRun + 1;
      else if (lowRun > 0)
      begin
        checkValue(curName, "data phase cycles", curWrite ? 3 : 2, lowRun + 1);
        lenSeen = 1'b1;
        lowRun  = 0;
      end
      if (start || finish)
      begin
        if (haveTest)
          reportTest();
        haveTest   = start;
        curName    = expName;
        curAddr    = expAddr;
        curWrite   = expWrite;
        curWData   = expWData;
        curRData   = expRData;
        isXfer     = (expTrans == TransNonSeq) || (expTrans == TransSeq);
        enCount    = 0;
        lenSeen    = 1'b0;
        testErrors = 0;
      end
    end
  end

endmodule

`default_nettype wire

/* tests/ahbToApbBridgeTb.sv */
/*
  Testbench top: clock, reset, transfer table, AHB master and APB slave model
*/
`timescale 1ns/10ps
`default_nettype none

module ahbToApbBridgeTb;
  import bridgePkg::*;

  localparam int NumEntries = 11;
  // Reset, at most 8 cycles per entry, then some slack
  localparam int CycleLimit = 16 + 8 * NumEntries + 50;

  typedef struct {
    logic [95:0] name;
    hTransT      trans;
    ahbAddrT     addr;
    logic        write;
    ahbDataT     wdata;
    ahbDataT     rdata;
  } entryT;

  logic    HCLK;
  logic    HRESETn;
  logic    HSELAHBAPB;
  hTransT  HTRANS;
  logic    HWRITE;
  ahbAddrT HADDR;
  ahbDataT HWDATA;
  logic    HREADYIn;
  logic    HREADYOut;
  hRespT   HRESP;
  ahbDataT HRDATA;
  apbCtrlT apb;
  ahbDataT PWDATA;
  ahbDataT PRDATA;

  entryT   entries [NumEntries];
  entryT   curEntry;
  logic    forceLow;
  logic    start;
  logic    finish;
  ahbDataT slaveData;
  int      cycles;
  int      testCount;
  int      failCount;
  int      errorCount;

  always #2 HCLK = ~HCLK;

  // Other slaves may stall the system bus while the bridge is idle
  assign HREADYIn = HREADYOut && !forceLow;

  ahbToApbBridge i_dut (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .HSELAHBAPB (HSELAHBAPB),
    .HTRANS     (HTRANS),
    .HWRITE     (HWRITE),
    .HADDR      (HADDR),
    .HWDATA     (HWDATA),
    .HREADYIn   (HREADYIn),
    .HREADYOut  (HREADYOut),
    .HRESP      (HRESP),
    .HRDATA     (HRDATA),
    .apb        (apb),
    .PWDATA     (PWDATA),
    .PRDATA     (PRDATA)
  );

  apbMonitor i_monitor (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .HREADYOut  (HREADYOut),
    .HRESP      (HRESP),
    .HRDATA     (HRDATA),
    .apb        (apb),
    .PWDATA     (PWDATA),
    .start      (start),
    .finish     (finish),
    .expName    (curEntry.name),
    .expTrans   (curEntry.trans),
    .expAddr    (curEntry.addr),
    .expWrite   (curEntry.write),
    .expWData   (curEntry.wdata),
    .expRData   (curEntry.rdata),
    .testCount  (testCount),
    .failCount  (failCount),
    .errorCount (errorCount)
  );

  // ----------------------------------------------------------------------
  // APB slave model
  // ----------------------------------------------------------------------
  // Read data picked up at the end of setup, held through enable
  always @(posedge HCLK)
  begin
    if ((apb.pSelRegs || apb.pSelIntc) && !apb.pEnable)
      slaveData <= curEntry.rdata;
  end

  assign PRDATA = (apb.pSelRegs || apb.pSelIntc) ? slaveData : '0;

  // Cycle limit
  always @(posedge HCLK)
  begin
    cycles = cycles + 1;
    if (cycles >= CycleLimit)
    begin
      $display("Run stopped after %0d cycles, the transfers did not complete", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic putEntry(input int idx, input logic [95:0] name, input hTransT trans,
                          input ahbAddrT addr, input logic write, input ahbDataT wdata,
                          input ahbDataT rdata);
    entries[idx].name  = name;
    entries[idx].trans = trans;
    entries[idx].addr  = addr;
    entries[idx].write = write;
    entries[idx].wdata = wdata;
    entries[idx].rdata = rdata;
  endtask

  // Idle cycles, some with a transfer the system bus holds off
  task automatic idleGap();
    int gap;
    gap = $urandom % 3;
    for (int i = 0; i < gap; i++)
    begin
      // The first cycle may still be the enable cycle of the last transfer
      forceLow   = ($urandom % 2 == 1) && (i > 0);
      HSELAHBAPB = forceLow;
      HTRANS     = forceLow ? TransNonSeq : TransIdle;
      @(negedge HCLK);
    end
    forceLow = 1'b0;
  endtask

  // Address phase, then data phase until the bridge is ready again
  task automatic runEntry(input int idx);
    logic sawLow;
    idleGap();
    curEntry   = entries[idx];
    HSELAHBAPB = 1'b1;
    HTRANS     = curEntry.trans;
    HWRITE     = curEntry.write;
    HADDR      = curEntry.addr;
    start      = 1'b1;
    @(negedge HCLK);
    start  = 1'b0;
    HTRANS = TransIdle;
    HWDATA = curEntry.wdata;
    sawLow = 1'b0;
    if ((curEntry.trans == TransNonSeq) || (curEntry.trans == TransSeq))
    begin
      while (!sawLow || !HREADYOut)
      begin
        if (!HREADYOut)
          sawLow = 1'b1;
        @(negedge HCLK);
      end
    end
  endtask

  initial
  begin
    void'($urandom(82834));
    HCLK       = 1'b0;
    HRESETn    = 1'b0;
    HSELAHBAPB = 1'b0;
    HTRANS     = TransIdle;
    HWRITE     = 1'b0;
    HADDR      = '0;
    HWDATA     = '0;
    forceLow   = 1'b0;
    start      = 1'b0;
    finish     = 1'b0;
    slaveData  = '0;
    cycles     = 0;
    // Name, HTRANS, HADDR, write, write data, slave read data
    putEntry(0,  "regRead", TransNonSeq, 32'h0000_0010, 1'b0, 32'h0, 32'hA5A5_0001);
    putEntry(1,  "regWrite", TransNonSeq, 32'h0000_0014, 1'b1, 32'h1234_5678, 32'h0);
    putEntry(2,  "intcRead", TransNonSeq, 32'h0100_0008, 1'b0, 32'h0, 32'hCAFE_0002);
    putEntry(3,  "intcWrite", TransNonSeq, 32'h0100_000C, 1'b1, 32'hDEAD_BEEF, 32'h0);
    putEntry(4,  "unmapRead", TransNonSeq, 32'h0500_0020, 1'b0, 32'h0, 32'h5555_0003);
    putEntry(5,  "unmapWrite", TransNonSeq, 32'h0F00_1234, 1'b1, 32'h0BAD_F00D, 32'h0);
    putEntry(6,  "idleEntry", TransIdle, 32'h0000_0030, 1'b0, 32'h0, 32'h0);
    putEntry(7,  "busyEntry", TransBusy, 32'h0100_0034, 1'b1, 32'h9999_0000, 32'h0);
    putEntry(8,  "seqRead", TransSeq, 32'h0000_0100, 1'b0, 32'h0, 32'h1111_2222);
    putEntry(9,  "seqWrite", TransSeq, 32'h0100_0104, 1'b1, 32'h3333_4444, 32'h0);
    putEntry(10, "highAddr", TransNonSeq, 32'hF0FF_ABCD, 1'b0, 32'h0, 32'h7777_8888);
    curEntry = entries[0];
    repeat (16) @(negedge HCLK);
    HRESETn = 1'b1;
    @(negedge HCLK);
    for (int i = 0; i < NumEntries; i++)
      runEntry(i);
    HSELAHBAPB = 1'b0;
    repeat (3) @(negedge HCLK);
    finish = 1'b1;
    @(negedge HCLK);
    finish = 1'b0;
    @(negedge HCLK);
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             testCount, testCount - failCount, failCount, errorCount);
    if ((failCount == 0) && (errorCount == 0) && (testCount == NumEntries))
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
src/bridgePkg.sv
src/ahbCapture.sv
src/bridgeFsm.sv
src/apbDriver.sv
src/ahbToApbBridge.sv
tests/apbMonitor.sv
tests/ahbToApbBridgeTb.sv

/* Makefile */
TOP = ahbToApbBridgeTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -Wall -f src.f --top-module $(TOP) --Mdir obj_dir -o simv

run: compile
	./obj_dir/simv | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
